//--- hdl/soc_macros.svh
// Fabric address map and sizes

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ----------------------------------------------------------------------------
// Boot ROM
// ----------------------------------------------------------------------------
`define SOC_ROM_BASE   32'h0001_0000
`define SOC_ROM_WORDS  16
// ROM word k holds k * SOC_ROM_MULT, truncated to 32 bits
`define SOC_ROM_MULT   32'h9E37_79B9

// ----------------------------------------------------------------------------
// RAM bank
// ----------------------------------------------------------------------------
`define SOC_RAM_BASE   32'h8000_0000
`define SOC_RAM_WORDS  64

// ----------------------------------------------------------------------------
// GPIO window, no device behind it
// ----------------------------------------------------------------------------
`define SOC_GPIO_BASE  32'h4000_0000
`define SOC_GPIO_BYTES 4096

// Cycles the core debug request stays blocked after reset
`define SOC_DEBUG_HOLDOFF 20

`endif

//--- hdl/soc_pkg.sv
// Fabric bus types

package soc_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Target of a decoded request
  typedef enum logic [1:0] {
    REG_ROM  = 2'd0,
    REG_RAM  = 2'd1,
    REG_GPIO = 2'd2,
    REG_NONE = 2'd3
  } region_e;

  // Request as seen on the requester side
  typedef struct packed {
    bus_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } bus_req_t;

  typedef struct packed {
    resp_e       resp;
    logic [31:0] rdata;
  } bus_rsp_t;

  // Stage 1 output, address reduced to a word index
  typedef struct packed {
    region_e     region;
    bus_op_e     op;
    logic [5:0]  idx;
    logic [31:0] wdata;
    logic [3:0]  be;
  } dec_req_t;

endpackage

//--- hdl/req_decoder.sv
// Request decode stage
`timescale 1ns/1ns

`include "soc_macros.svh"

module req_decoder (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  input  soc_pkg::bus_req_t  req_i,
  output logic               req_ready_o,
  input  logic               advance_i,
  output logic               dec_valid_o,
  output soc_pkg::dec_req_t  dec_req_o
);

  import soc_pkg::*;

  logic [31:0] rom_off;
  logic [31:0] ram_off;
  region_e     region_d;
  dec_req_t    dec_d;
  logic        dec_valid_q;
  dec_req_t    dec_req_q;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  assign rom_off = req_i.addr - `SOC_ROM_BASE;
  assign ram_off = req_i.addr - `SOC_RAM_BASE;

  always_comb begin
    if (req_i.addr >= `SOC_ROM_BASE &&
        req_i.addr < `SOC_ROM_BASE + `SOC_ROM_WORDS * 4) begin
      region_d = REG_ROM;
    end else if (req_i.addr >= `SOC_RAM_BASE &&
                 req_i.addr < `SOC_RAM_BASE + `SOC_RAM_WORDS * 4) begin
      region_d = REG_RAM;
    end else if (req_i.addr >= `SOC_GPIO_BASE &&
                 req_i.addr < `SOC_GPIO_BASE + `SOC_GPIO_BYTES) begin
      region_d = REG_GPIO;
    end else begin
      region_d = REG_NONE;
    end
  end

  always_comb begin
    dec_d.region = region_d;
    dec_d.op     = req_i.op;
    // Index only matters for ROM and RAM
    dec_d.idx    = (region_d == REG_RAM) ? 6'(ram_off >> 2) : 6'(rom_off >> 2);
    dec_d.wdata  = req_i.wdata;
    dec_d.be     = req_i.be;
  end

  // --------------------------------------------------------------------------
  // Stage 1 register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_q <= 1'b0;
    end else if (advance_i) begin
      dec_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      dec_req_q <= dec_d;
    end
  end

  assign req_ready_o = advance_i;
  assign dec_valid_o = dec_valid_q;
  assign dec_req_o   = dec_req_q;

endmodule

//--- hdl/boot_rom.sv
// Boot ROM with registered read data
`timescale 1ns/1ns

`include "soc_macros.svh"

module boot_rom (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               advance_i,
  input  logic               dec_valid_i,
  input  soc_pkg::dec_req_t  dec_req_i,
  output logic [31:0]        rdata_o
);

  import soc_pkg::*;

  localparam int RomAw = $clog2(`SOC_ROM_WORDS);

  logic [31:0] rom_tbl [`SOC_ROM_WORDS];
  logic        rd_en;
  logic [31:0] rdata_q;

  // Word k = k * multiplier
  for (genvar k = 0; k < `SOC_ROM_WORDS; k++) begin : g_tbl
    assign rom_tbl[k] = 32'(k * `SOC_ROM_MULT);
  end

  // Writes are ignored here, resp_merge flags them
  assign rd_en = advance_i && dec_valid_i &&
                 dec_req_i.region == REG_ROM && dec_req_i.op == OP_READ;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= rom_tbl[dec_req_i.idx[RomAw-1:0]];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hdl/sram_bank.sv
// RAM bank with byte enables
`timescale 1ns/1ns

`include "soc_macros.svh"

module sram_bank (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               advance_i,
  input  logic               dec_valid_i,
  input  soc_pkg::dec_req_t  dec_req_i,
  output logic [31:0]        rdata_o
);

  import soc_pkg::*;

  localparam int RamAw = $clog2(`SOC_RAM_WORDS);

  logic [31:0]      mem [`SOC_RAM_WORDS];
  logic [31:0]      rdata_q;
  logic             hit;
  logic [RamAw-1:0] waddr;

  assign hit   = advance_i && dec_valid_i && dec_req_i.region == REG_RAM;
  assign waddr = dec_req_i.idx[RamAw-1:0];

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `SOC_RAM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (hit && dec_req_i.op == OP_WRITE) begin
      for (int b = 0; b < 4; b++) begin
        if (dec_req_i.be[b]) begin
          mem[waddr][8*b +: 8] <= dec_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read data, same edge as the stage 2 load
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (hit && dec_req_i.op == OP_READ) begin
      rdata_q <= mem[waddr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hdl/resp_merge.sv
// Response stage and pipeline control
`timescale 1ns/1ns

module resp_merge (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               dec_valid_i,
  input  soc_pkg::dec_req_t  dec_req_i,
  input  logic [31:0]        rom_rdata_i,
  input  logic [31:0]        ram_rdata_i,
  input  logic               rsp_ready_i,
  output logic               rsp_valid_o,
  output soc_pkg::bus_rsp_t  rsp_o,
  output logic               advance_o
);

  import soc_pkg::*;

  logic     valid_q;
  region_e  region_q;
  bus_op_e  op_q;
  bus_rsp_t rsp_d;

  // Whole pipeline moves when the output slot is free or being drained
  assign advance_o = !valid_q || rsp_ready_i;

  // --------------------------------------------------------------------------
  // Stage 2 tag register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (advance_o) begin
      valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_o) begin
      region_q <= dec_req_i.region;
      op_q     <= dec_req_i.op;
    end
  end

  // --------------------------------------------------------------------------
  // Response select
  // --------------------------------------------------------------------------
  always_comb begin
    rsp_d.resp  = RESP_OKAY;
    rsp_d.rdata = '0;
    unique case (region_q)
      REG_ROM: begin
        if (op_q == OP_READ) begin
          rsp_d.rdata = rom_rdata_i;
        end else begin
          rsp_d.resp = RESP_SLVERR;
        end
      end
      REG_RAM: begin
        // Writes answer OKAY with zero data
        if (op_q == OP_READ) begin
          rsp_d.rdata = ram_rdata_i;
        end
      end
      REG_GPIO: rsp_d.resp = RESP_SLVERR;
      default:  rsp_d.resp = RESP_DECERR;
    endcase
  end

  assign rsp_valid_o = valid_q;
  assign rsp_o       = rsp_d;

endmodule

//--- hdl/debug_gate.sv
// Debug request hold-off and enable
`timescale 1ns/1ns

`include "soc_macros.svh"

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int CntW = $clog2(`SOC_DEBUG_HOLDOFF + 1);

  logic [CntW-1:0] cnt_q;
  logic            holdoff;

  assign holdoff = (cnt_q != '0);

  // Counts down once after reset, then parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntW'(`SOC_DEBUG_HOLDOFF);
    end else if (holdoff) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = !holdoff && debug_req_i && debug_en_i;

endmodule

//--- hdl/soc_fabric_top.sv
// Fabric slice top level
`timescale 1ns/1ns

module soc_fabric_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Request channel
  input  logic               req_valid_i,
  input  soc_pkg::bus_req_t  req_i,
  output logic               req_ready_o,
  // Response channel
  output logic               rsp_valid_o,
  output soc_pkg::bus_rsp_t  rsp_o,
  input  logic               rsp_ready_i,
  // Debug
  input  logic               debug_req_i,
  input  logic               debug_en_i,
  output logic               debug_req_o
);

  import soc_pkg::*;

  logic        advance;
  logic        dec_valid;
  dec_req_t    dec_req;
  logic [31:0] rom_rdata;
  logic [31:0] ram_rdata;

  // --------------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------------
  req_decoder u_req_decoder (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .req_ready_o ( req_ready_o ),
    .advance_i   ( advance     ),
    .dec_valid_o ( dec_valid   ),
    .dec_req_o   ( dec_req     )
  );

  boot_rom u_boot_rom (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .advance_i   ( advance   ),
    .dec_valid_i ( dec_valid ),
    .dec_req_i   ( dec_req   ),
    .rdata_o     ( rom_rdata )
  );

  sram_bank u_sram_bank (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .advance_i   ( advance   ),
    .dec_valid_i ( dec_valid ),
    .dec_req_i   ( dec_req   ),
    .rdata_o     ( ram_rdata )
  );

  resp_merge u_resp_merge (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .dec_valid_i ( dec_valid   ),
    .dec_req_i   ( dec_req     ),
    .rom_rdata_i ( rom_rdata   ),
    .ram_rdata_i ( ram_rdata   ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .advance_o   ( advance     )
  );

  // --------------------------------------------------------------------------
  // Debug request gate
  // --------------------------------------------------------------------------
  debug_gate u_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- dv/soc_fabric_chk.sv
// Fabric slice protocol assertions
`timescale 1ns/1ns

module soc_fabric_chk (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_ready_o,
  input logic              rsp_valid_o,
  input soc_pkg::bus_rsp_t rsp_o,
  input logic              rsp_ready_i
);

  logic stalled;

  assign stalled = rsp_valid_o && !rsp_ready_i;

  // Held response keeps its value
  rsp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stalled |=> rsp_valid_o && $stable(rsp_o))
    else $error("response changed or dropped while stalled");

  no_accept_stalled_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stalled |-> !req_ready_o)
    else $error("request accepted while response stalled");

  // Output register empty coming out of reset
  reset_empty_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !rsp_valid_o)
    else $error("response valid right after reset");

endmodule

bind soc_fabric_top soc_fabric_chk u_soc_fabric_chk (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .req_ready_o ( req_ready_o ),
  .rsp_valid_o ( rsp_valid_o ),
  .rsp_o       ( rsp_o       ),
  .rsp_ready_i ( rsp_ready_i )
);

//--- dv/tb_soc_fabric.sv
// Fabric slice testbench
`timescale 1ns/1ns

`include "soc_macros.svh"

module tb_soc_fabric;

  import soc_pkg::*;

  localparam int TimeoutCycles = 200;

  logic     clk_i;
  logic     rst_ni;
  logic     req_valid_i;
  bus_req_t req_i;
  logic     req_ready_o;
  logic     rsp_valid_o;
  bus_rsp_t rsp_o;
  logic     rsp_ready_i;
  logic     debug_req_i;
  logic     debug_en_i;
  logic     debug_req_o;

  logic [31:0] rng = 32'h673b5fa1;
  logic [31:0] shadow_ram [`SOC_RAM_WORDS];
  bus_req_t    pending_q [$];
  string       cur_test;
  bit          bp_on;
  bit          aborted;
  int          check_cnt = 0;
  int          err_cnt = 0;
  int          accept_cnt = 0;
  int          rsp_cnt = 0;
  int          test_chk0;
  int          test_err0;

  soc_fabric_top u_soc_fabric_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic bit in_window(input logic [31:0] addr, input logic [31:0] base,
                                   input logic [31:0] bytes);
    return addr >= base && (addr - base) < bytes;
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  task automatic model_access(input bus_req_t r, output bus_rsp_t exp);
    logic [31:0] k;
    exp.resp  = RESP_OKAY;
    exp.rdata = '0;
    if (in_window(r.addr, `SOC_ROM_BASE, `SOC_ROM_WORDS * 4)) begin
      k = (r.addr - `SOC_ROM_BASE) >> 2;
      if (r.op == OP_READ) begin
        exp.rdata = k * `SOC_ROM_MULT;
      end else begin
        exp.resp = RESP_SLVERR;
      end
    end else if (in_window(r.addr, `SOC_RAM_BASE, `SOC_RAM_WORDS * 4)) begin
      k = (r.addr - `SOC_RAM_BASE) >> 2;
      if (r.op == OP_READ) begin
        exp.rdata = shadow_ram[k];
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (r.be[b]) begin
            shadow_ram[k][8*b +: 8] = r.wdata[8*b +: 8];
          end
        end
      end
    end else if (in_window(r.addr, `SOC_GPIO_BASE, `SOC_GPIO_BYTES)) begin
      exp.resp = RESP_SLVERR;
    end else begin
      exp.resp = RESP_DECERR;
    end
  endtask

  // Responses pop before the same-edge request push
  always @(posedge clk_i) begin
    bus_rsp_t exp;
    if (rst_ni) begin
      if (rsp_valid_o && rsp_ready_i) begin
        rsp_cnt++;
        if (pending_q.size() == 0) begin
          err_cnt++;
          $display("%s: got a response with no request outstanding", cur_test);
        end else begin
          model_access(pending_q.pop_front(), exp);
          compare(cur_test, exp, rsp_o);
        end
      end
      if (req_valid_i && req_ready_o) begin
        pending_q.push_back(req_i);
        accept_cnt++;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  task automatic tick();
    @(posedge clk_i);
    rsp_ready_i <= bp_on ? (next_rand() > 32'h6000_0000) : 1'b1;
  endtask

  function automatic bus_req_t make_req(input int region, input bus_op_e op);
    bus_req_t    r;
    logic [31:0] rnd;
    rnd     = next_rand();
    r.op    = op;
    r.wdata = next_rand();
    r.be    = rnd[3:0];
    case (region)
      0: r.addr = `SOC_ROM_BASE + ((rnd >> 4) % `SOC_ROM_WORDS) * 4;
      1: r.addr = `SOC_RAM_BASE + ((rnd >> 4) % `SOC_RAM_WORDS) * 4;
      2: r.addr = `SOC_GPIO_BASE + ((rnd >> 8) % `SOC_GPIO_BYTES);
      // Either high space or just past the RAM window
      default: r.addr = rnd[4] ? {4'hF, rnd[31:4]} :
                        `SOC_RAM_BASE + `SOC_RAM_WORDS * 4 + {24'b0, rnd[12:5]};
    endcase
    return r;
  endfunction

  function automatic bus_op_e rand_op();
    return (next_rand() > 32'h8000_0000) ? OP_WRITE : OP_READ;
  endfunction

  task automatic send_req(input bus_req_t r);
    int gap;
    int waited;
    bit accepted;
    if (aborted) return;
    gap = int'(next_rand() % 3);
    repeat (gap) begin
      req_valid_i <= 1'b0;
      tick();
    end
    req_valid_i <= 1'b1;
    req_i       <= r;
    accepted = 1'b0;
    for (waited = 0; waited < TimeoutCycles && !accepted; waited++) begin
      tick();
      accepted = req_ready_o;
    end
    if (!accepted) begin
      $display("%s: timeout, request was never accepted", cur_test);
      aborted = 1'b1;
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic drain();
    int waited;
    if (aborted) return;
    req_valid_i <= 1'b0;
    waited = 0;
    // First look one edge later, once the last accepted request is queued
    do begin
      tick();
      waited++;
    end while ((pending_q.size() != 0 || rsp_valid_o) && waited < TimeoutCycles);
    if (pending_q.size() != 0 || rsp_valid_o) begin
      $display("%s: timeout, %0d responses never arrived", cur_test, pending_q.size());
      aborted = 1'b1;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_chk0 = check_cnt;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    drain();
    compare({cur_test, " count"}, accept_cnt, rsp_cnt);
    $display("test %s done: %0d checks, %0d errors", cur_test,
             check_cnt - test_chk0, err_cnt - test_err0);
  endtask

  // ---------------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------------
  task automatic test_debug();
    start_test("debug_gate");
    for (int i = 0; i < `SOC_DEBUG_HOLDOFF; i++) begin
      tick();
      compare(cur_test, 1'b0, debug_req_o);
    end
    for (int i = 0; i < 40; i++) begin
      tick();
      compare(cur_test, debug_req_i & debug_en_i, debug_req_o);
      debug_req_i <= next_rand() > 32'h8000_0000;
      debug_en_i  <= next_rand() > 32'h8000_0000;
    end
    end_test();
  endtask

  task automatic test_requests(input string name, input int rom_rd, input int ram_rd,
                               input int ram_rand, input int err_n, input int mixed_n);
    bus_req_t r;
    start_test(name);
    for (int k = 0; k < rom_rd; k++) begin
      r      = make_req(0, OP_READ);
      r.addr = `SOC_ROM_BASE + k * 4;
      send_req(r);
    end
    // Unwritten words first
    for (int i = 0; i < ram_rd; i++) begin
      r      = make_req(1, OP_READ);
      r.addr = `SOC_RAM_BASE + i * 32;
      send_req(r);
    end
    for (int i = 0; i < ram_rand; i++) begin
      send_req(make_req(1, rand_op()));
    end
    for (int i = 0; i < err_n; i++) begin
      send_req(make_req(0, OP_WRITE));
      send_req(make_req(2, rand_op()));
      send_req(make_req(3, rand_op()));
    end
    for (int i = 0; i < mixed_n; i++) begin
      send_req(make_req(int'(next_rand() % 4), rand_op()));
    end
    end_test();
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b1;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    bp_on       = 1'b0;
    aborted     = 1'b0;
    for (int w = 0; w < `SOC_RAM_WORDS; w++) begin
      shadow_ram[w] = '0;
    end
    repeat (8) tick();
    rst_ni <= 1'b1;
    // Hold-off window starts at the release edge
    test_debug();
    test_requests("rom_read", `SOC_ROM_WORDS, 0, 0, 0, 0);
    test_requests("ram_rw", 0, 8, 60, 0, 0);
    test_requests("error_resp", 0, 0, 0, 8, 0);
    bp_on = 1'b1;
    test_requests("backpressure", 0, 0, 0, 0, 100);
    bp_on = 1'b0;
    $display("tests 5, checks %0d, errors %0d, aborted %0d", check_cnt, err_cnt, aborted);
    if (err_cnt == 0 && !aborted) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hdl
hdl/soc_pkg.sv
hdl/req_decoder.sv
hdl/boot_rom.sv
hdl/sram_bank.sv
hdl/resp_merge.sv
hdl/debug_gate.sv
hdl/soc_fabric_top.sv
dv/soc_fabric_chk.sv
dv/tb_soc_fabric.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_soc_fabric \
  || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/Vtb_soc_fabric 2>&1)"
echo "$out"
grep -qx "TESTBENCH PASSED" <<< "$out" && exit 0 || exit 1
